// ==== compile.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
gcd_unit.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
retire_stage.sv
mips_top.sv
tb_mips.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the mips testbench with verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_mips \
        --Mdir obj_dir -o Vtb_mips; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_mips > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "STATUS: PASS" "$LOG"; then
    exit 0
else
    exit 1
fi

// ==== tb_mips.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"

module tb_mips;

    localparam int wait_limit = 50;
    // 53 instructions are issued over all tests
    localparam int n_instr = 53;
    localparam int cycle_limit = n_instr * 60 + 100;
    localparam logic [4:0] bad_addr = 5'd0;
    localparam logic [4:0] reg_addr [6] = '{
        `MIPS_REG_ADDR_0, `MIPS_REG_ADDR_1, `MIPS_REG_ADDR_2,
        `MIPS_REG_ADDR_3, `MIPS_REG_ADDR_4, `MIPS_REG_ADDR_5
    };
    // add, and, or, nor, sll, srl
    localparam logic [6:0] ops [6] = '{
        7'b0100000, 7'b0100100, 7'b0100101, 7'b0100111, 7'b0000000, 7'b0000010
    };
    localparam logic [6:0] func_or  = 7'b0100101;
    localparam logic [6:0] func_gcd = 7'b1111000;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    logic [31:0]                instruction;
    logic [`MIPS_OUT_SEL_W-1:0] output_reg;
    logic                       out_valid;
    logic                       instruction_fail;
    core_pkg::word_t            out_1, out_2, out_3, out_4;

    core_pkg::word_t model [6];
    string           cur_test;
    int              test_errs, n_pass, n_fail, cycles;

    mips_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .instruction      (instruction),
        .output_reg       (output_reg),
        .out_valid        (out_valid),
        .instruction_fail (instruction_fail),
        .out_1            (out_1),
        .out_2            (out_2),
        .out_3            (out_3),
        .out_4            (out_4)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rtype_word(input logic [6:0] func, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [3:0] shamt);
        return {6'b000000, rs, rt, rd, shamt, func};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rs, input logic [4:0] rt,
                                              input core_pkg::word_t imm);
        return {6'b001000, rs, rt, imm};
    endfunction

    function automatic logic [19:0] make_sel(input logic [4:0] a0, input logic [4:0] a1,
                                             input logic [4:0] a2, input logic [4:0] a3);
        return {a3, a2, a1, a0};
    endfunction

    // unknown addresses read zero
    function automatic core_pkg::word_t sel_value(input logic [4:0] addr);
        core_pkg::word_t v;
        v = '0;
        for (int k = 0; k < 6; k++) begin
            if (reg_addr[k] == addr) v = model[k];
        end
        return v;
    endfunction

    function automatic core_pkg::out_words_t model_words(input logic [19:0] sel);
        core_pkg::out_words_t w;
        w.w1 = sel_value(sel[4:0]);
        w.w2 = sel_value(sel[9:5]);
        w.w3 = sel_value(sel[14:10]);
        w.w4 = sel_value(sel[19:15]);
        return w;
    endfunction

    function automatic core_pkg::out_words_t dut_words();
        core_pkg::out_words_t w;
        w.w1 = out_1;
        w.w2 = out_2;
        w.w3 = out_3;
        w.w4 = out_4;
        return w;
    endfunction

    function automatic core_pkg::word_t alu_ref(input logic [6:0] func, input core_pkg::word_t a,
                                                input core_pkg::word_t b, input logic [3:0] shamt);
        case (func)
            7'b0100000: return a + b;
            7'b0100100: return a & b;
            7'b0100101: return a | b;
            7'b0100111: return ~(a | b);
            7'b0000000: return b << shamt;
            7'b0000010: return b >> shamt;
            default:    return '0;
        endcase
    endfunction

    // plain euclid, independent of the binary method
    function automatic core_pkg::word_t ref_gcd(input core_pkg::word_t a, input core_pkg::word_t b);
        core_pkg::word_t t;
        while (b != 0) begin
            t = a % b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    function automatic core_pkg::word_t rand_nonzero();
        core_pkg::word_t v;
        v = core_pkg::word_t'($urandom());
        return (v == 0) ? core_pkg::word_t'(1) : v;
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: ok", cur_test);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic check_words(input string label, input core_pkg::out_words_t exp,
                               input core_pkg::out_words_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", cur_test, label, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string label, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s fail flag: expected %b actual %b", cur_test, label, exp, act);
            test_errs++;
        end
    endtask

    // drive on the falling edge, sample on later falling edges
    task automatic issue(input logic [31:0] instr, input logic [19:0] sel, output int lat,
                         output logic got, output core_pkg::out_words_t act,
                         output logic fail_seen);
        @(negedge clk);
        in_valid    = 1'b1;
        instruction = instr;
        output_reg  = sel;
        lat         = 0;
        got         = 1'b0;
        act         = '0;
        fail_seen   = 1'b0;
        while (!got && lat < wait_limit) begin
            @(negedge clk);
            lat++;
            in_valid = 1'b0;
            if (out_valid) begin
                got       = 1'b1;
                act       = dut_words();
                fail_seen = instruction_fail;
            end
        end
    endtask

    // model must already hold the expected register values
    task automatic run_and_check(input string label, input logic [31:0] instr,
                                 input logic [19:0] sel, input logic exp_fail, output int lat);
        core_pkg::out_words_t act;
        logic                 got, fail_seen;
        issue(instr, sel, lat, got, act, fail_seen);
        if (!got) begin
            $display("%s %s: no out_valid within %0d cycles", cur_test, label, wait_limit);
            test_errs++;
        end else begin
            check_flag(label, exp_fail, fail_seen);
            check_words(label, exp_fail ? core_pkg::out_words_t'('0) : model_words(sel), act);
        end
    endtask

    task automatic set_reg(input int k, input core_pkg::word_t value);
        core_pkg::word_t imm;
        int              lat;
        imm      = value - model[k];
        model[k] = value;
        run_and_check($sformatf("load r%0d", k), addi_word(reg_addr[k], reg_addr[k], imm),
                      make_sel(reg_addr[k], reg_addr[(k+1)%6], reg_addr[(k+2)%6],
                               reg_addr[(k+3)%6]), 1'b0, lat);
    endtask

    // or r0 with itself leaves every register as it was
    task automatic read_back(input string label);
        int lat;
        run_and_check({label, " r0-r3"}, rtype_word(func_or, reg_addr[0], reg_addr[0],
                      reg_addr[0], 4'd0), make_sel(reg_addr[0], reg_addr[1], reg_addr[2],
                      reg_addr[3]), 1'b0, lat);
        run_and_check({label, " r4-r5"}, rtype_word(func_or, reg_addr[0], reg_addr[0],
                      reg_addr[0], 4'd0), make_sel(reg_addr[4], reg_addr[5], reg_addr[0],
                      reg_addr[1]), 1'b0, lat);
    endtask

    task automatic test_load();
        begin_test("load");
        for (int k = 0; k < 6; k++) begin
            set_reg(k, core_pkg::word_t'($urandom()));
        end
        end_test();
    endtask

    task automatic test_alu();
        int          rs, rt, rd, lat;
        logic [3:0]  shamt;
        begin_test("alu");
        for (int rep = 0; rep < 2; rep++) begin
            for (int f = 0; f < 6; f++) begin
                rs        = $urandom_range(5, 0);
                rt        = $urandom_range(5, 0);
                rd        = $urandom_range(5, 0);
                shamt     = 4'($urandom_range(15, 0));
                model[rd] = alu_ref(ops[f], model[rs], model[rt], shamt);
                run_and_check($sformatf("func %b", ops[f]),
                              rtype_word(ops[f], reg_addr[rs], reg_addr[rt], reg_addr[rd], shamt),
                              make_sel(reg_addr[rd], reg_addr[rs], reg_addr[rt],
                                       reg_addr[(rd+1)%6]), 1'b0, lat);
                // out_valid rises on the edge after the accepting edge
                if (lat != 2) begin
                    $display("%s func %b: out_valid came %0d falling edges after issue, not 2",
                             cur_test, ops[f], lat);
                    test_errs++;
                end
            end
        end
        end_test();
    endtask

    task automatic gcd_case(input string label, input core_pkg::word_t va,
                            input core_pkg::word_t vb);
        int lat;
        set_reg(0, va);
        set_reg(1, vb);
        model[2] = ref_gcd(va, vb);
        run_and_check(label, rtype_word(func_gcd, reg_addr[0], reg_addr[1], reg_addr[2], 4'd0),
                      make_sel(reg_addr[2], reg_addr[0], reg_addr[1], reg_addr[3]), 1'b0, lat);
    endtask

    task automatic test_gcd();
        int              c;
        core_pkg::word_t va, vb;
        begin_test("gcd");
        for (int i = 0; i < 4; i++) begin
            // shared factor so the result is rarely 1
            c  = $urandom_range(64, 1);
            va = core_pkg::word_t'(c * $urandom_range(1000, 1));
            vb = core_pkg::word_t'(c * $urandom_range(1000, 1));
            gcd_case($sformatf("random %0d", i), va, vb);
        end
        gcd_case("operand one", 16'd1, rand_nonzero());
        va = rand_nonzero();
        gcd_case("equal operands", va, va);
        gcd_case("powers of two", 16'h0400, 16'h0040);
        end_test();
    endtask

    task automatic test_fail();
        logic [19:0] sel;
        int          lat;
        begin_test("fail");
        sel = make_sel(reg_addr[0], reg_addr[1], reg_addr[2], reg_addr[3]);
        run_and_check("unknown opcode", {6'b000010, reg_addr[0], reg_addr[1], 16'h1234},
                      sel, 1'b1, lat);
        run_and_check("unknown function", rtype_word(7'b0000001, reg_addr[0], reg_addr[1],
                      reg_addr[2], 4'd0), sel, 1'b1, lat);
        run_and_check("invalid rs", addi_word(bad_addr, reg_addr[1], 16'h0005), sel, 1'b1, lat);
        run_and_check("invalid rt", rtype_word(ops[0], reg_addr[0], bad_addr, reg_addr[2], 4'd0),
                      sel, 1'b1, lat);
        run_and_check("invalid rd", rtype_word(ops[0], reg_addr[0], reg_addr[1], bad_addr, 4'd0),
                      sel, 1'b1, lat);
        set_reg(5, '0);
        run_and_check("gcd zero operand", rtype_word(func_gcd, reg_addr[0], reg_addr[5],
                      reg_addr[2], 4'd0), sel, 1'b1, lat);
        read_back("after failures");
        end_test();
    endtask

    task automatic test_busy();
        core_pkg::word_t imm1, imm2;
        logic [19:0]     sel;
        logic            seen;
        int              lat;
        begin_test("busy");
        imm1     = core_pkg::word_t'($urandom());
        imm2     = core_pkg::word_t'($urandom()) | 16'h0001;
        model[3] = model[3] + imm1;
        sel      = make_sel(reg_addr[3], reg_addr[4], reg_addr[2], reg_addr[1]);
        @(negedge clk);
        in_valid    = 1'b1;
        instruction = addi_word(reg_addr[3], reg_addr[3], imm1);
        output_reg  = sel;
        // second instruction held only while the first is in flight
        @(negedge clk);
        instruction = addi_word(reg_addr[4], reg_addr[4], imm2);
        @(negedge clk);
        in_valid = 1'b0;
        if (!out_valid) begin
            $display("%s: first instruction did not retire after one cycle", cur_test);
            test_errs++;
        end else begin
            check_flag("first", 1'b0, instruction_fail);
            check_words("first", model_words(sel), dut_words());
        end
        seen = 1'b0;
        repeat (5) begin
            @(negedge clk);
            if (out_valid) seen = 1'b1;
        end
        if (seen) begin
            $display("%s: instruction offered while busy was executed", cur_test);
            test_errs++;
        end
        read_back("after busy");
        run_and_check("unknown select", rtype_word(func_or, reg_addr[3], reg_addr[3],
                      reg_addr[3], 4'd0), make_sel(reg_addr[3], bad_addr, reg_addr[4],
                      bad_addr), 1'b0, lat);
        end_test();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        instruction = '0;
        output_reg  = '0;
        cycles      = 0;
        n_pass      = 0;
        n_fail      = 0;
        test_errs   = 0;
        for (int k = 0; k < 6; k++) begin
            model[k] = '0;
        end
        void'($urandom(32'hcdb4_19e8));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_load();
        test_alu();
        test_gcd();
        test_fail();
        test_busy();

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== mips_top.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic [31:0]                instruction,
    input  logic [`MIPS_OUT_SEL_W-1:0] output_reg,
    output logic                       out_valid,
    output logic                       instruction_fail,
    output core_pkg::word_t            out_1,
    output core_pkg::word_t            out_2,
    output core_pkg::word_t            out_3,
    output core_pkg::word_t            out_4
);

    isa_pkg::decoded_t      dec;
    isa_pkg::reg_idx_t      out_sel [4];
    logic                   start;
    logic                   retire;
    core_pkg::word_t        rs_val, rt_val;
    core_pkg::exec_result_t result;
    core_pkg::reg_wr_t      wr;
    core_pkg::out_words_t   words_rf, words_out;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instruction (instruction),
        .output_reg  (output_reg),
        .retire      (retire),
        .dec         (dec),
        .start       (start),
        .out_sel     (out_sel)
    );

    reg_file u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .rs_idx    (dec.rs),
        .rt_idx    (dec.rt),
        .out_sel   (out_sel),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .out_words (words_rf)
    );

    execute_stage u_exec (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .dec    (dec),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .result (result)
    );

    retire_stage u_retire (
        .clk              (clk),
        .rst_n            (rst_n),
        .result           (result),
        .words_in         (words_rf),
        .wr               (wr),
        .retire           (retire),
        .out_valid        (out_valid),
        .instruction_fail (instruction_fail),
        .words_out        (words_out)
    );

    assign out_1 = words_out.w1;
    assign out_2 = words_out.w2;
    assign out_3 = words_out.w3;
    assign out_4 = words_out.w4;

endmodule

// ==== retire_stage.sv ====
`timescale 1ns/10ps

module retire_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::exec_result_t result,
    input  core_pkg::out_words_t   words_in,
    output core_pkg::reg_wr_t      wr,
    output logic                   retire,
    output logic                   out_valid,
    output logic                   instruction_fail,
    output core_pkg::out_words_t   words_out
);

    logic show;

    // write lands on the same edge that raises out_valid
    assign wr.en   = result.valid && !result.fail;
    assign wr.idx  = result.rd;
    assign wr.data = result.data;
    assign retire  = result.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid        <= 1'b0;
            instruction_fail <= 1'b0;
        end else begin
            out_valid        <= result.valid;
            instruction_fail <= result.valid && result.fail;
        end
    end

    assign show      = out_valid && !instruction_fail;
    assign words_out = show ? words_in : '0;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  isa_pkg::decoded_t      dec,
    input  core_pkg::word_t        rs_val,
    input  core_pkg::word_t        rt_val,
    output core_pkg::exec_result_t result
);

    core_pkg::word_t opnd_b, alu_out, gcd_result;
    logic            is_gcd, gcd_zero, fail, gcd_start, gcd_done, pending;

    assign opnd_b    = dec.is_rtype ? rt_val : dec.imm;
    assign is_gcd    = dec.is_rtype && (dec.func == isa_pkg::func_gcd);
    assign gcd_zero  = is_gcd && ((rs_val == '0) || (rt_val == '0));
    // one fail decision for decode and operand errors
    assign fail      = dec.decode_err || gcd_zero;
    assign gcd_start = start && is_gcd && !fail;

    always_comb begin
        if (!dec.is_rtype) begin
            alu_out = rs_val + opnd_b;
        end else begin
            case (dec.func)
                isa_pkg::func_add: alu_out = rs_val + opnd_b;
                isa_pkg::func_and: alu_out = rs_val & opnd_b;
                isa_pkg::func_or:  alu_out = rs_val | opnd_b;
                isa_pkg::func_nor: alu_out = ~(rs_val | opnd_b);
                isa_pkg::func_sll: alu_out = rt_val << dec.shamt;
                isa_pkg::func_srl: alu_out = rt_val >> dec.shamt;
                default:           alu_out = '0;
            endcase
        end
    end

    // waiting on the gcd unit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (gcd_start) begin
            pending <= 1'b1;
        end else if (gcd_done) begin
            pending <= 1'b0;
        end
    end

    gcd_unit u_gcd (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (gcd_start),
        .a_in   (rs_val),
        .b_in   (rt_val),
        .done   (gcd_done),
        .result (gcd_result)
    );

    assign result.valid = (start && (fail || !is_gcd)) || (pending && gcd_done);
    assign result.fail  = start && fail;
    assign result.rd    = dec.rd;
    assign result.data  = pending ? gcd_result : alu_out;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::reg_wr_t    wr,
    input  isa_pkg::reg_idx_t    rs_idx,
    input  isa_pkg::reg_idx_t    rt_idx,
    input  isa_pkg::reg_idx_t    out_sel [4],
    output core_pkg::word_t      rs_val,
    output core_pkg::word_t      rt_val,
    output core_pkg::out_words_t out_words
);

    core_pkg::word_t regs [`MIPS_NUM_REGS];
    core_pkg::word_t sel_val [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.idx < `MIPS_NUM_REGS) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // index 7 and other empty slots read as zero
    assign rs_val = (rs_idx < `MIPS_NUM_REGS) ? regs[rs_idx] : '0;
    assign rt_val = (rt_idx < `MIPS_NUM_REGS) ? regs[rt_idx] : '0;

    for (genvar g = 0; g < 4; g++) begin : g_out_mux
        assign sel_val[g] = (out_sel[g] < `MIPS_NUM_REGS) ? regs[out_sel[g]] : '0;
    end

    assign out_words = '{w1: sel_val[0], w2: sel_val[1], w3: sel_val[2], w4: sel_val[3]};

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"

module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [31:0]                 instruction,
    input  logic [`MIPS_OUT_SEL_W-1:0]  output_reg,
    input  logic                        retire,
    output isa_pkg::decoded_t           dec,
    output logic                        start,
    output isa_pkg::reg_idx_t           out_sel [4]
);

    logic        busy;
    logic        accept;
    logic [31:0] instr_q;
    logic        op_known;
    logic        func_known;

    assign accept = in_valid && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (retire) begin
                busy <= 1'b0;
            end
        end
    end

    // instruction and output selects held for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instruction;
            for (int i = 0; i < 4; i++) begin
                out_sel[i] <= isa_pkg::addr_to_idx(output_reg[5*i +: 5]);
            end
        end
    end

    always_comb begin
        op_known = (instr_q[31:26] == isa_pkg::op_rtype) ||
                   (instr_q[31:26] == isa_pkg::op_addi);
        case (instr_q[6:0])
            isa_pkg::func_add, isa_pkg::func_and, isa_pkg::func_or,
            isa_pkg::func_nor, isa_pkg::func_sll, isa_pkg::func_srl,
            isa_pkg::func_gcd: func_known = 1'b1;
            default:           func_known = 1'b0;
        endcase

        dec.is_rtype = (instr_q[31:26] == isa_pkg::op_rtype);
        dec.func     = isa_pkg::func_e'(instr_q[6:0]);
        dec.shamt    = instr_q[10:7];
        dec.imm      = instr_q[15:0];
        dec.rs       = isa_pkg::addr_to_idx(instr_q[25:21]);
        dec.rt       = isa_pkg::addr_to_idx(instr_q[20:16]);
        // addi writes back to rt
        dec.rd       = dec.is_rtype ? isa_pkg::addr_to_idx(instr_q[15:11]) : dec.rt;

        dec.decode_err = !op_known ||
                         (dec.rs == isa_pkg::reg_none) ||
                         (dec.rt == isa_pkg::reg_none) ||
                         (dec.is_rtype && !func_known) ||
                         (dec.is_rtype && dec.rd == isa_pkg::reg_none);
    end

endmodule

// ==== gcd_unit.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"

module gcd_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  core_pkg::word_t a_in,
    input  core_pkg::word_t b_in,
    output logic            done,
    output core_pkg::word_t result
);

    localparam int cnt_w = $clog2(`MIPS_DATA_W);
    typedef logic [cnt_w-1:0] cnt_t;

    core_pkg::word_t a_q, b_q, a_nxt, b_nxt;
    core_pkg::word_t diff, diff_odd, survivor;
    cnt_t            pow_q, pow_nxt, tz_a, tz_b;
    logic            running, finish, a_ge_b;

    // position of the lowest set bit, zero for a zero word
    function automatic cnt_t trail_zeros(input core_pkg::word_t v);
        cnt_t cnt;
        cnt = '0;
        for (int i = `MIPS_DATA_W - 1; i >= 0; i--) begin
            if (v[i]) cnt = cnt_t'(i);
        end
        return cnt;
    endfunction

    always_comb begin
        tz_a     = trail_zeros(a_q);
        tz_b     = trail_zeros(b_q);
        a_ge_b   = a_q >= b_q;
        diff     = a_ge_b ? a_q - b_q : b_q - a_q;
        diff_odd = diff >> trail_zeros(diff);
        finish   = (a_q == '0) || (b_q == '0) || (a_q == 1) || (b_q == 1) || (a_q == b_q);

        a_nxt   = a_q;
        b_nxt   = b_q;
        pow_nxt = pow_q;
        if (!a_q[0] || !b_q[0]) begin
            // strip both, only the shared power of two is kept
            a_nxt   = a_q >> tz_a;
            b_nxt   = b_q >> tz_b;
            pow_nxt = pow_q + ((tz_a < tz_b) ? tz_a : tz_b);
        end else if (a_ge_b) begin
            a_nxt = diff_odd;
        end else begin
            b_nxt = diff_odd;
        end

        if ((a_q == 1) || (b_q == 1)) begin
            survivor = core_pkg::word_t'(1);
        end else if (a_q == '0) begin
            survivor = b_q;
        end else begin
            survivor = a_q;
        end
    end

    assign done   = running && finish;
    assign result = survivor << pow_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q     <= '0;
            b_q     <= '0;
            pow_q   <= '0;
            running <= 1'b0;
        end else if (start) begin
            a_q     <= a_in;
            b_q     <= b_in;
            pow_q   <= '0;
            running <= 1'b1;
        end else if (running) begin
            if (finish) begin
                running <= 1'b0;
            end else begin
                a_q   <= a_nxt;
                b_q   <= b_nxt;
                pow_q <= pow_nxt;
            end
        end
    end

endmodule

// ==== core_pkg.sv ====
`include "mips_config.svh"

package core_pkg;

    typedef logic [`MIPS_DATA_W-1:0] word_t;

    // single register write port
    typedef struct packed {
        logic              en;
        isa_pkg::reg_idx_t idx;
        word_t             data;
    } reg_wr_t;

    // valid is a one-cycle pulse per instruction
    typedef struct packed {
        logic              valid;
        logic              fail;
        isa_pkg::reg_idx_t rd;
        word_t             data;
    } exec_result_t;

    typedef struct packed {
        word_t w1;
        word_t w2;
        word_t w3;
        word_t w4;
    } out_words_t;

endpackage

// ==== isa_pkg.sv ====
`include "mips_config.svh"

package isa_pkg;

    typedef enum logic [`MIPS_OPCODE_W-1:0] {
        op_rtype = 6'b000000,
        op_addi  = 6'b001000
    } opcode_e;

    typedef enum logic [`MIPS_FUNC_W-1:0] {
        func_add = 7'b0100000,
        func_and = 7'b0100100,
        func_or  = 7'b0100101,
        func_nor = 7'b0100111,
        func_sll = 7'b0000000,
        func_srl = 7'b0000010,
        func_gcd = 7'b1111000
    } func_e;

    // physical register index, 7 is the empty slot
    typedef logic [2:0] reg_idx_t;
    localparam reg_idx_t reg_none = 3'd7;

    typedef struct packed {
        logic                      is_rtype;
        func_e                     func;
        logic [`MIPS_SHAMT_W-1:0]  shamt;
        logic [15:0]               imm;
        reg_idx_t                  rs;
        reg_idx_t                  rt;
        reg_idx_t                  rd;
        logic                      decode_err;
    } decoded_t;

    function automatic reg_idx_t addr_to_idx(input logic [`MIPS_ADDR_W-1:0] addr);
        reg_idx_t idx;
        case (addr)
            `MIPS_REG_ADDR_0: idx = 3'd0;
            `MIPS_REG_ADDR_1: idx = 3'd1;
            `MIPS_REG_ADDR_2: idx = 3'd2;
            `MIPS_REG_ADDR_3: idx = 3'd3;
            `MIPS_REG_ADDR_4: idx = 3'd4;
            `MIPS_REG_ADDR_5: idx = 3'd5;
            default:          idx = reg_none;
        endcase
        return idx;
    endfunction

endpackage

// ==== mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath and register file size
`define MIPS_DATA_W      16
`define MIPS_NUM_REGS    6

// instruction field widths
`define MIPS_OPCODE_W    6
`define MIPS_ADDR_W      5
`define MIPS_SHAMT_W     4
`define MIPS_FUNC_W      7

// architectural addresses of the six registers
`define MIPS_REG_ADDR_0  5'd17
`define MIPS_REG_ADDR_1  5'd18
`define MIPS_REG_ADDR_2  5'd8
`define MIPS_REG_ADDR_3  5'd23
`define MIPS_REG_ADDR_4  5'd31
`define MIPS_REG_ADDR_5  5'd16

// four 5-bit output selects
`define MIPS_OUT_SEL_W   20

`endif
